// File: Makefile
# Verilator flow for the coefficient sampler
VERILATOR  ?= verilator
TB_TOP     ?= sampler_tb
RTL_TOP    ?= sampler_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/coef_writer.sv
`timescale 1ns/100ps

module coef_writer #(
  parameter int NUM_RD = 4
) (
  input  logic                             clk,
  input  logic                             rst_b,
  input  logic                             start_i,
  input  logic                             busy_i,
  input  logic [sampler_pkg::CNT_W-1:0]    target_i,
  sample_ifc.wrt                           smp,
  output logic [sampler_pkg::CNT_W-1:0]    count_o,
  output logic                             run_end_o,
  output logic                             mem_we_o,
  output logic [5:0]                       mem_addr_o,
  output sampler_pkg::coef_t [NUM_RD-1:0]  mem_wdata_o,
  output logic [NUM_RD-1:0]                mem_lane_o
);
  import sampler_pkg::*;

  // One extra bit so count plus a lane index never wraps
  localparam int IDX_W = CNT_W + 1;

  logic              pop;
  logic [NUM_RD-1:0] lane;
  logic [CNT_W-1:0]  count_q;
  logic [CNT_W-1:0]  count_next;
  logic [5:0]        addr_q;

  // Outside a run every leftover group is flushed and discarded
  assign smp.flush = ~busy_i;

  // Same pop rule as the buffer, so exactly one group is seen per pop
  assign pop = smp.rd_valid[NUM_RD-1] | (smp.flush & smp.rd_valid[0]);

  // A lane is written only if its coefficient still falls below the target
  always_comb begin
    logic [IDX_W-1:0] idx;
    lane = '0;
    for (int i = 0; i < NUM_RD; i++) begin
      idx     = {1'b0, count_q} + IDX_W'(i);
      lane[i] = busy_i & pop & smp.rd_valid[i] & (idx < {1'b0, target_i});
    end
  end

  // Lanes are contiguous, so adding them gives the new count
  always_comb begin
    count_next = count_q;
    for (int i = 0; i < NUM_RD; i++) begin
      count_next = count_next + CNT_W'(lane[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      count_q   <= '0;
      addr_q    <= '0;
      run_end_o <= 1'b0;
    end else begin
      // Pulses once, on the group that brings the count to the target
      run_end_o <= (|lane) & (count_next == target_i);
      if (start_i) begin
        count_q <= '0;
        addr_q  <= '0;
      end else if (|lane) begin
        count_q <= count_next;
        addr_q  <= addr_q + 6'd1;
      end
    end
  end

  // Write port follows buffer state directly so a group is stored as it appears
  assign mem_we_o   = |lane;
  assign mem_addr_o = addr_q;
  assign mem_lane_o = lane;
  assign count_o    = count_q;

  // Lanes that are not written carry zero rather than stale buffer content
  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      mem_wdata_o[i] = lane[i] ? smp.rd_data[i] : '0;
    end
  end

endmodule

// File: logic/msg_buffer.sv
`timescale 1ns/100ps

module msg_buffer #(
  parameter int NUM_WR = 5,
  parameter int NUM_RD = 4
) (
  input  logic      clk,
  input  logic      rst_b,
  sample_ifc.bufr   smp
);
  import sampler_pkg::*;

  // Enough room for one pending group plus one full write beat
  localparam int DEPTH = NUM_WR + NUM_RD;
  localparam int CNT_BW = $clog2(DEPTH + 1);

  // Buffer entries, entry 0 is the oldest sample
  coef_t [DEPTH-1:0] buf_q;
  coef_t [DEPTH-1:0] buf_shift;
  coef_t [DEPTH-1:0] buf_d;
  logic  [DEPTH-1:0] vld_q;
  logic  [DEPTH-1:0] vld_shift;
  logic  [DEPTH-1:0] vld_d;

  // Incoming beat widened to the buffer depth and moved to its landing spot
  coef_t [DEPTH-1:0] wr_ext;
  coef_t [DEPTH-1:0] wr_shift;
  logic  [DEPTH-1:0] wr_vext;
  logic  [DEPTH-1:0] wr_vshift;

  logic              do_rd;
  logic              do_wr;
  logic [CNT_BW-1:0] num_valid;
  logic [CNT_BW-1:0] shamt;

  // Full once the entries a wide beat could need past a pop are not all free
  // With a read side at least as wide as the write side it never fills
  generate
    if (NUM_WR <= NUM_RD) begin : g_never_full
      assign smp.full = 1'b0;
    end else begin : g_full
      assign smp.full = vld_q[DEPTH-(NUM_WR-NUM_RD)];
    end
  endgenerate

  // Pop a whole group, or any leftover while flushing
  assign do_rd = vld_q[NUM_RD-1] | (smp.flush & vld_q[0]);
  assign do_wr = (|smp.wr_valid) & ~smp.full;

  // Valid entries are contiguous so the count is also the first free slot
  always_comb begin
    num_valid = '0;
    for (int i = 0; i < DEPTH; i++) begin
      num_valid = num_valid + CNT_BW'(vld_q[i]);
    end
  end

  // A flush may pop fewer than NUM_RD entries, so the offset saturates at zero
  always_comb begin
    if (!do_rd) begin
      shamt = num_valid;
    end else if (num_valid > CNT_BW'(NUM_RD)) begin
      shamt = num_valid - CNT_BW'(NUM_RD);
    end else begin
      shamt = '0;
    end
  end

  always_comb begin
    wr_ext  = '0;
    wr_vext = '0;
    for (int i = 0; i < NUM_WR; i++) begin
      wr_ext[i]  = smp.wr_data[i];
      wr_vext[i] = smp.wr_valid[i] & do_wr;
    end
    wr_shift  = wr_ext << (shamt * COEF_W);
    wr_vshift = wr_vext << shamt;
  end

  // Drop the popped group, then append the new beat behind what is left
  always_comb begin
    buf_shift = do_rd ? (buf_q >> (NUM_RD * COEF_W)) : buf_q;
    vld_shift = do_rd ? (vld_q >> NUM_RD) : vld_q;
    for (int i = 0; i < DEPTH; i++) begin
      buf_d[i] = wr_vshift[i] ? wr_shift[i] : buf_shift[i];
    end
    vld_d = vld_shift | wr_vshift;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      vld_q <= '0;
    end else if (do_rd | do_wr) begin
      vld_q <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    if (do_rd | do_wr) begin
      buf_q <= buf_d;
    end
  end

  // The oldest group is always on view to the writer
  assign smp.rd_valid = vld_q[NUM_RD-1:0];
  assign smp.rd_data  = buf_q[NUM_RD-1:0];

endmodule

// File: logic/rej_filter.sv
`timescale 1ns/100ps

module rej_filter #(
  parameter int NUM_WR = 5
) (
  input  logic                             clk,
  input  logic                             rst_b,
  input  logic                             busy_i,
  input  sampler_pkg::coef_t               bound_i,
  input  logic                             cand_valid_i,
  input  sampler_pkg::coef_t [NUM_WR-1:0]  cand_i,
  output logic                             cand_ready_o,
  sample_ifc.filt                          smp
);
  import sampler_pkg::*;

  // Survivors of the current beat, packed into the low slots
  logic  [NUM_WR-1:0] keep_valid;
  coef_t [NUM_WR-1:0] keep_data;

  // A beat is taken from the source on this cycle
  logic take;

  // Room exists when the register is empty or the buffer takes its content now
  // Nothing is taken outside a run
  assign cand_ready_o = busy_i & (~(|smp.wr_valid) | ~smp.full);
  assign take         = cand_valid_i & cand_ready_o;

  // Walk the candidates in order and drop each kept one into the next free slot
  // Order among survivors is preserved so the stream stays in sequence
  always_comb begin
    logic [$clog2(NUM_WR+1)-1:0] slot;
    slot       = '0;
    keep_valid = '0;
    keep_data  = '0;
    for (int i = 0; i < NUM_WR; i++) begin
      if (cand_i[i] < bound_i) begin
        keep_valid[slot] = 1'b1;
        keep_data[slot]  = cand_i[i];
        slot             = slot + 1'b1;
      end
    end
  end

  // Valid bits load on a new beat and clear once the buffer has taken them
  // While the buffer is full the register simply holds
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      smp.wr_valid <= '0;
    end else if (take) begin
      smp.wr_valid <= keep_valid;
    end else if (!smp.full) begin
      smp.wr_valid <= '0;
    end
  end

  // Sample values only matter where the valid bit is set
  always_ff @(posedge clk) begin
    if (take) begin
      smp.wr_data <= keep_data;
    end
  end

endmodule

// File: logic/sample_ifc.sv
`timescale 1ns/100ps

interface sample_ifc #(
  parameter int NUM_WR = 5,
  parameter int NUM_RD = 4
);
  import sampler_pkg::*;

  // Compacted survivors from the filter, valid bits are contiguous from bit 0
  logic  [NUM_WR-1:0] wr_valid;
  coef_t [NUM_WR-1:0] wr_data;

  // Buffer cannot take a whole write beat
  logic full;

  // Oldest NUM_RD buffer entries, a group is ready once the top one is valid
  logic  [NUM_RD-1:0] rd_valid;
  coef_t [NUM_RD-1:0] rd_data;

  // Pops partial groups so the buffer empties between runs
  logic flush;

  modport filt (output wr_valid, output wr_data, input full);

  // Named bufr since buf is a reserved gate keyword
  modport bufr (
    input  wr_valid, input wr_data, input flush,
    output full, output rd_valid, output rd_data
  );

  modport wrt (input rd_valid, input rd_data, output flush);

endinterface

// File: logic/sampler_pkg.sv
package sampler_pkg;

  // Width of one coefficient and of one raw candidate from the source
  localparam int COEF_W = 12;

  // One coefficient as it travels through the filter, buffer and writer
  typedef logic [COEF_W-1:0] coef_t;

  // Coefficient counter width, wide enough to hold a full polynomial of 256
  localparam int CNT_W = 9;

  // Rejection bound after reset, the usual modulus q
  localparam coef_t DEF_BOUND = 12'd3329;

  // Number of coefficients per run after reset
  localparam logic [CNT_W-1:0] DEF_TARGET = 9'd256;

  // Register map of the control port
  // Bit 0 of a CTRL write starts a run
  localparam logic [1:0] REG_CTRL = 2'd0;
  // Candidates strictly below this value are kept
  localparam logic [1:0] REG_BOUND = 2'd1;
  // Coefficient count at which a run ends
  localparam logic [1:0] REG_TARGET = 2'd2;
  // Busy in bit 0, done in bit 1, current count above them
  localparam logic [1:0] REG_STATUS = 2'd3;

  // Data width of the register port
  localparam int REG_DW = 16;

endpackage

// File: logic/sampler_regs.sv
`timescale 1ns/100ps

module sampler_regs (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic                              reg_we_i,
  input  logic [1:0]                        reg_addr_i,
  input  logic [sampler_pkg::REG_DW-1:0]    reg_wdata_i,
  output logic [sampler_pkg::REG_DW-1:0]    reg_rdata_o,
  input  logic [sampler_pkg::CNT_W-1:0]     count_i,
  input  logic                              run_end_i,
  output sampler_pkg::coef_t                bound_o,
  output logic [sampler_pkg::CNT_W-1:0]     target_o,
  output logic                              start_o,
  output logic                              busy_o,
  output logic                              done_o
);
  import sampler_pkg::*;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      bound_o  <= DEF_BOUND;
      target_o <= DEF_TARGET;
      start_o  <= 1'b0;
      busy_o   <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      // A start request during a run is ignored
      start_o <= reg_we_i & (reg_addr_i == REG_CTRL) & reg_wdata_i[0] & ~busy_o;
      if (reg_we_i && reg_addr_i == REG_BOUND) begin
        bound_o <= reg_wdata_i[COEF_W-1:0];
      end
      if (reg_we_i && reg_addr_i == REG_TARGET) begin
        target_o <= reg_wdata_i[CNT_W-1:0];
      end
      // Busy rises on the same edge the writer clears its counter
      if (start_o) begin
        busy_o <= 1'b1;
        done_o <= 1'b0;
      end else if (run_end_i) begin
        busy_o <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  // CTRL is write only and reads as zero
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      REG_BOUND:  reg_rdata_o[COEF_W-1:0] = bound_o;
      REG_TARGET: reg_rdata_o[CNT_W-1:0]  = target_o;
      REG_STATUS: reg_rdata_o[CNT_W+1:0]  = {count_i, done_o, busy_o};
      default:    reg_rdata_o = '0;
    endcase
  end

endmodule

// File: logic/sampler_top.sv
`timescale 1ns/100ps

module sampler_top #(
  parameter int NUM_WR = 5,
  parameter int NUM_RD = 4
) (
  input  logic                             clk,
  input  logic                             rst_b,
  input  logic                             cand_valid_i,
  input  sampler_pkg::coef_t [NUM_WR-1:0]  cand_i,
  output logic                             cand_ready_o,
  input  logic                             reg_we_i,
  input  logic [1:0]                       reg_addr_i,
  input  logic [sampler_pkg::REG_DW-1:0]   reg_wdata_i,
  output logic [sampler_pkg::REG_DW-1:0]   reg_rdata_o,
  output logic                             mem_we_o,
  output logic [5:0]                       mem_addr_o,
  output sampler_pkg::coef_t [NUM_RD-1:0]  mem_wdata_o,
  output logic [NUM_RD-1:0]                mem_lane_o,
  output logic                             busy_o,
  output logic                             done_o
);
  import sampler_pkg::*;

  // Run control shared by the register block and the datapath
  coef_t            bound;
  logic [CNT_W-1:0] target;
  logic [CNT_W-1:0] count;
  logic             start;
  logic             run_end;

  // Sample path from filter through buffer to writer
  sample_ifc #(.NUM_WR(NUM_WR), .NUM_RD(NUM_RD)) u_smp ();

  sampler_regs u_regs (
    .clk         (clk),
    .rst_b       (rst_b),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .count_i     (count),
    .run_end_i   (run_end),
    .bound_o     (bound),
    .target_o    (target),
    .start_o     (start),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  rej_filter #(.NUM_WR(NUM_WR)) u_filter (
    .clk          (clk),
    .rst_b        (rst_b),
    .busy_i       (busy_o),
    .bound_i      (bound),
    .cand_valid_i (cand_valid_i),
    .cand_i       (cand_i),
    .cand_ready_o (cand_ready_o),
    .smp          (u_smp.filt)
  );

  msg_buffer #(.NUM_WR(NUM_WR), .NUM_RD(NUM_RD)) u_buffer (
    .clk   (clk),
    .rst_b (rst_b),
    .smp   (u_smp.bufr)
  );

  coef_writer #(.NUM_RD(NUM_RD)) u_writer (
    .clk         (clk),
    .rst_b       (rst_b),
    .start_i     (start),
    .busy_i      (busy_o),
    .target_i    (target),
    .smp         (u_smp.wrt),
    .count_o     (count),
    .run_end_o   (run_end),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_lane_o  (mem_lane_o)
  );

endmodule

// File: src.f
logic/sampler_pkg.sv
logic/sample_ifc.sv
logic/rej_filter.sv
logic/msg_buffer.sv
logic/coef_writer.sv
logic/sampler_regs.sv
logic/sampler_top.sv
tb/sampler_tb.sv

// File: tb/sampler_tb.sv
`timescale 1ns/100ps

module sampler_tb;
  import sampler_pkg::*;

  localparam int NUM_WR = 5;
  localparam int NUM_RD = 4;
  localparam int MEM_WORDS = 64 * NUM_RD;
  localparam int BEAT_TIMEOUT = 200;
  localparam int DONE_TIMEOUT = 4000;
  // Flush pops one partial group per cycle, a few cycles empty the pipe
  localparam int DRAIN_CYCLES = 4;
  localparam int SEQ_BELOW = 0;
  localparam int RAND_ANY = 1;
  localparam int RAND_BELOW = 2;
  localparam logic [31:0] RAND_SEED = 32'h27f9_668a;

  logic                    clk;
  logic                    rst_b;
  logic                    cand_valid_i;
  coef_t [NUM_WR-1:0]      cand_i;
  logic                    cand_ready_o;
  logic                    reg_we_i;
  logic [1:0]              reg_addr_i;
  logic [REG_DW-1:0]       reg_wdata_i;
  logic [REG_DW-1:0]       reg_rdata_o;
  logic                    mem_we_o;
  logic [5:0]              mem_addr_o;
  coef_t [NUM_RD-1:0]      mem_wdata_o;
  logic [NUM_RD-1:0]       mem_lane_o;
  logic                    busy_o;
  logic                    done_o;

  // Memory model, one coefficient per lane of each group address
  coef_t             mem_model [0:MEM_WORDS-1];
  logic [NUM_RD-1:0] last_lane;
  logic [5:0]        last_addr;
  // Kept candidates in arrival order, the expected memory image
  coef_t             ref_q [$];
  coef_t             cur_bound;
  int                stall_cycles;
  int unsigned       seed_dummy;

  sampler_top u_dut (
    .clk          (clk),
    .rst_b        (rst_b),
    .cand_valid_i (cand_valid_i),
    .cand_i       (cand_i),
    .cand_ready_o (cand_ready_o),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_lane_o   (mem_lane_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Write port outputs are stable mid cycle, so the model samples on the falling edge
  always @(negedge clk) begin
    if (mem_we_o) begin
      for (int i = 0; i < NUM_RD; i++) begin
        if (mem_lane_o[i]) begin
          mem_model[int'(mem_addr_o) * NUM_RD + i] = mem_wdata_o[i];
        end
      end
      last_lane = mem_lane_o;
      last_addr = mem_addr_o;
    end
  end

  // The filter packs survivors low, so n valid bits must be exactly the lowest n
  always @(negedge clk) begin
    if (rst_b) begin
      check_eq("u_smp.wr_valid", u_dut.u_smp.wr_valid,
               (32'd1 << $countones(u_dut.u_smp.wr_valid)) - 32'd1);
    end
  end

  // Untouched words keep a value tied to every address bit
  function automatic coef_t fill_word(input int pos);
    return coef_t'(pos) ^ 12'hc3a;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic init_mem();
    for (int p = 0; p < MEM_WORDS; p++) begin
      mem_model[p] = fill_word(p);
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [REG_DW-1:0] data);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk);
    reg_we_i <= 1'b0;
  endtask

  // Read data is combinational, so it is taken half a cycle after the address
  task automatic read_reg(input logic [1:0] addr, output logic [REG_DW-1:0] data);
    reg_addr_i <= addr;
    @(negedge clk);
    data = reg_rdata_o;
    @(posedge clk);
  endtask

  // Ready comes from registers only, so its value at the falling edge holds at the next rise
  task automatic send_beat(input coef_t [NUM_WR-1:0] beat);
    int   waits;
    logic ok;
    waits = 0;
    ok = 1'b0;
    cand_valid_i <= 1'b1;
    cand_i       <= beat;
    while (!ok) begin
      @(negedge clk);
      ok = cand_ready_o;
      if (!ok && busy_o) stall_cycles++;
      @(posedge clk);
      waits++;
      if (!ok && waits > BEAT_TIMEOUT) begin
        abort_run("Timeout: a candidate beat was never accepted");
      end
    end
  endtask

  task automatic wait_done();
    int waits;
    waits = 0;
    do begin
      @(negedge clk);
      waits++;
      if (waits > DONE_TIMEOUT) abort_run("Timeout: done_o never rose at the end of the run");
    end while (!done_o);
  endtask

  // Runs one sampling pass and compares memory with the kept candidates
  task automatic run_stream(input int kind, input int target);
    coef_t [NUM_WR-1:0] beat;
    coef_t              v;
    int                 need;
    int                 n;
    init_mem();
    ref_q.delete();
    stall_cycles = 0;
    n = 0;
    // A group pops only when complete, so the last one needs filling up
    need = ((target + NUM_RD - 1) / NUM_RD) * NUM_RD;
    write_reg(REG_TARGET, REG_DW'(target));
    write_reg(REG_CTRL, 16'h0001);
    while (ref_q.size() < need) begin
      for (int i = 0; i < NUM_WR; i++) begin
        case (kind)
          SEQ_BELOW: v = coef_t'((n * 7 + 3) % int'(cur_bound));
          RAND_ANY:  v = coef_t'($urandom);
          default:   v = coef_t'($urandom % cur_bound);
        endcase
        beat[i] = v;
        if (v < cur_bound) ref_q.push_back(v);
        n++;
      end
      send_beat(beat);
    end
    cand_valid_i <= 1'b0;
    wait_done();
    check_eq("busy_o", busy_o, 1'b0);
    check_eq("cand_ready_o", cand_ready_o, 1'b0);
    for (int p = 0; p < MEM_WORDS; p++) begin
      if (p < target) begin
        check_eq($sformatf("mem_wdata_o[%0d]", p), mem_model[p], ref_q[p]);
      end else begin
        check_eq($sformatf("mem_wdata_o[%0d]", p), mem_model[p], fill_word(p));
      end
    end
    @(posedge clk);
  endtask

  task automatic test_reg_defaults();
    logic [REG_DW-1:0] rd;
    check_eq("mem_we_o", mem_we_o, 1'b0);
    check_eq("busy_o", busy_o, 1'b0);
    check_eq("done_o", done_o, 1'b0);
    read_reg(REG_BOUND, rd);
    check_eq("bound", rd, 3329);
    read_reg(REG_TARGET, rd);
    check_eq("target", rd, 256);
    read_reg(REG_STATUS, rd);
    check_eq("status", rd, 0);
    write_reg(REG_BOUND, 16'h0abc);
    read_reg(REG_BOUND, rd);
    check_eq("bound", rd, 16'h0abc);
    write_reg(REG_TARGET, 16'h007f);
    read_reg(REG_TARGET, rd);
    check_eq("target", rd, 16'h007f);
    write_reg(REG_BOUND, 16'd3329);
    cur_bound = 12'd3329;
  endtask

  // Done is a level, so it must still be set a full cycle after the run ended
  task automatic test_all_accepted();
    run_stream(SEQ_BELOW, 256);
    @(negedge clk);
    check_eq("done_o", done_o, 1'b1);
    @(posedge clk);
  endtask

  task automatic test_mixed_reject();
    logic [REG_DW-1:0] rd;
    run_stream(RAND_ANY, 256);
    read_reg(REG_STATUS, rd);
    check_eq("status count", rd[CNT_W+1:2], 256);
    check_eq("status done", rd[1], 1'b1);
    check_eq("status busy", rd[0], 1'b0);
  endtask

  // Five in and four out per cycle must fill the buffer and stall the source
  task automatic test_back_pressure();
    run_stream(RAND_BELOW, 256);
    check_eq("cand_ready_o low while busy", stall_cycles > 0, 1'b1);
  endtask

  task automatic test_short_target();
    run_stream(SEQ_BELOW, 10);
    check_eq("mem_lane_o", last_lane, 4'b0011);
    check_eq("mem_addr_o", last_addr, 6'd2);
    repeat (DRAIN_CYCLES) @(posedge clk);
    // Second run must restart at address 0 with none of the flushed leftovers
    run_stream(RAND_BELOW, 10);
    check_eq("mem_lane_o", last_lane, 4'b0011);
    check_eq("mem_addr_o", last_addr, 6'd2);
  endtask

  initial begin
    rst_b        = 1'b0;
    cand_valid_i = 1'b0;
    cand_i       = '0;
    reg_we_i     = 1'b0;
    reg_addr_i   = 2'd0;
    reg_wdata_i  = '0;
    cur_bound    = DEF_BOUND;
    stall_cycles = 0;
    seed_dummy   = $urandom(RAND_SEED);
    repeat (3) @(posedge clk);
    rst_b <= 1'b1;
    @(posedge clk);
    test_reg_defaults();
    test_all_accepted();
    test_mixed_reject();
    test_back_pressure();
    test_short_target();
    $display("=== PASS ===");
    $finish;
  end

endmodule
